// ==== Makefile ====
TOP = tbCpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f cpu.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cpu.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  isaPkg::word_t   a,
    input  isaPkg::word_t   b,
    input  pipePkg::aluOp_t op,
    output isaPkg::word_t   y
);
    import pipePkg::*;

    always_comb begin
        case (op)
            aluAdd: y = a + b;
            aluSub: y = a - b;
            aluAnd: y = a & b;
            aluOr:  y = a | b;
            // Immediate byte goes to the upper half
            aluLhi: y = {b[7:0], 8'h00};
            default: y = '0;
        endcase
    end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  isaPkg::instr_t instr,
    output pipePkg::ctrl_t ctrl
);
    import isaPkg::*;
    import pipePkg::*;

    always_comb begin
        ctrl = ctrlNop;
        case (instr.opcode)
            opAdi, opLwd: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.useRs     = 1'b1;
                ctrl.writeRt   = 1'b1;
                ctrl.aluOp     = aluAdd;
                // Load takes its result from memory
                ctrl.memRead   = (instr.opcode == opLwd);
                ctrl.memToReg  = (instr.opcode == opLwd);
            end
            opLhi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.writeRt   = 1'b1;
                ctrl.aluOp     = aluLhi;
            end
            opSwd: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.useRs     = 1'b1;
                ctrl.useRt     = 1'b1;
                ctrl.aluOp     = aluAdd;
            end
            opBne, opBeq: begin
                ctrl.isBranch   = 1'b1;
                ctrl.branchOnEq = (instr.opcode == opBeq);
                ctrl.useRs      = 1'b1;
                ctrl.useRt      = 1'b1;
            end
            opJmp: ctrl.isJump = 1'b1;
            opRtype: begin
                case (instr.func)
                    fnAdd, fnSub, fnAnd, fnOrr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.useRs    = 1'b1;
                        ctrl.useRt    = 1'b1;
                        ctrl.aluOp    = (instr.func == fnSub) ? aluSub :
                                        (instr.func == fnAnd) ? aluAnd :
                                        (instr.func == fnOrr) ? aluOr : aluAdd;
                    end
                    fnWwd: begin
                        ctrl.isWwd = 1'b1;
                        ctrl.useRs = 1'b1;
                    end
                    fnHlt: ctrl.isHalt = 1'b1;
                    default: ctrl = ctrlNop;
                endcase
            end
            default: ctrl = ctrlNop;
        endcase
    end

endmodule

// ==== cpu.f ====
isaPkg.sv
pipePkg.sv
controlUnit.sv
regFile.sv
alu.sv
hazardUnit.sv
datapath.sv
cpu.sv
cpu_checker.sv
tbCpu.sv

// ==== cpu.sv ====
`timescale 1ns/1ps

module cpu #(
    parameter isaPkg::word_t pcReset = '0
) (
    input  logic              Clk,
    input  logic              arstN,
    output isaPkg::word_t     imemAddr,
    input  isaPkg::word_t     imemData,
    output logic              imemRead,
    output pipePkg::dmemReq_t dmemReq,
    input  isaPkg::word_t     dmemRdata,
    output isaPkg::word_t     outputPort,
    output isaPkg::word_t     numInst,
    output logic              isHalted
);
    import isaPkg::*;
    import pipePkg::*;

    instr_t idInstr;
    ctrl_t  ctrl;

    controlUnit control0 (
        .instr(idInstr),
        .ctrl(ctrl)
    );

    datapath #(.pcReset(pcReset)) datapath0 (
        .Clk(Clk), .arstN(arstN),
        .ctrl(ctrl), .idInstr(idInstr),
        .imemAddr(imemAddr), .imemData(imemData), .imemRead(imemRead),
        .dmemReq(dmemReq), .dmemRdata(dmemRdata),
        .outputPort(outputPort), .numInst(numInst), .isHalted(isHalted)
    );

endmodule

// ==== cpu_checker.sv ====
`timescale 1ns/1ps

module cpuChecker (
    input logic              Clk,
    input logic              arstN,
    input pipePkg::dmemReq_t dmemReq,
    input logic              imemRead,
    input isaPkg::word_t     numInst,
    input logic              isHalted
);

    // One MEM slot, so one strobe at a time
    noReadWrite: assert property (@(posedge Clk) disable iff (!arstN)
        !(dmemReq.read && dmemReq.write))
        else $error("data memory read and write strobes high together");

    haltHolds: assert property (@(posedge Clk) disable iff (!arstN)
        isHalted |=> isHalted)
        else $error("isHalted dropped without reset");

    countRises: assert property (@(posedge Clk) disable iff (!arstN)
        numInst >= $past(numInst))
        else $error("numInst decreased");

    fetchStops: assert property (@(posedge Clk) imemRead == !isHalted)
        else $error("imemRead does not follow isHalted");

endmodule

bind cpu cpuChecker checker0 (
    .Clk(Clk), .arstN(arstN), .dmemReq(dmemReq), .imemRead(imemRead),
    .numInst(numInst), .isHalted(isHalted)
);

// ==== datapath.sv ====
`timescale 1ns/1ps

module datapath #(
    parameter isaPkg::word_t pcReset = '0
) (
    input  logic              Clk,
    input  logic              arstN,
    input  pipePkg::ctrl_t    ctrl,
    output isaPkg::instr_t    idInstr,
    output isaPkg::word_t     imemAddr,
    input  isaPkg::word_t     imemData,
    output logic              imemRead,
    output pipePkg::dmemReq_t dmemReq,
    input  isaPkg::word_t     dmemRdata,
    output isaPkg::word_t     outputPort,
    output isaPkg::word_t     numInst,
    output logic              isHalted
);
    import isaPkg::*;
    import pipePkg::*;

    word_t   pc;
    logic    fetchHalted;

    logic    ifBubble;
    word_t   ifPc;

    logic    exBubble;
    ctrl_t   exCtrl;
    word_t   exPc, exRdata1, exRdata2, exImm;
    regIdx_t exRs, exRt, exDest;

    logic    memBubble;
    ctrl_t   memCtrl;
    word_t   memResult, memStoreData;
    regIdx_t memDest;

    logic    wbBubble;
    ctrl_t   wbCtrl;
    word_t   wbResult, wbLoad, wbData;
    regIdx_t wbDest;

    word_t   idRdata1, idRdata2;
    word_t   opA, opB, aluY, exResult;
    fwdSel_t fwdA, fwdB;
    logic    stall, idActive, halt, jumpTaken, branchTaken;

    regFile regs0 (
        .Clk(Clk), .arstN(arstN),
        .rs(idInstr.rs), .rt(idInstr.rt),
        .rdata1(idRdata1), .rdata2(idRdata2),
        .we(wbCtrl.regWrite), .wa(wbDest), .wd(wbData)
    );

    hazardUnit hazard0 (
        .exRs(exRs), .exRt(exRt), .memRd(memDest), .wbRd(wbDest),
        .idRs(idInstr.rs), .idRt(idInstr.rt),
        .memRegWrite(memCtrl.regWrite), .wbRegWrite(wbCtrl.regWrite),
        .exMemRead(exCtrl.memRead),
        .idUseRs(!ifBubble && ctrl.useRs), .idUseRt(!ifBubble && ctrl.useRt),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall)
    );

    alu alu0 (
        .a(opA), .b(exCtrl.aluSrcImm ? exImm : opB), .op(exCtrl.aluOp), .y(aluY)
    );

    assign wbData = wbCtrl.memToReg ? wbLoad : wbResult;

    // Forwarding muxes
    assign opA = (fwdA == fwdExMem) ? memResult :
                 (fwdA == fwdMemWb) ? wbData : exRdata1;
    assign opB = (fwdB == fwdExMem) ? memResult :
                 (fwdB == fwdMemWb) ? wbData : exRdata2;
    assign exResult = exCtrl.isWwd ? opA : aluY;

    assign branchTaken = exCtrl.isBranch && ((opA == opB) == exCtrl.branchOnEq);
    // A flushed ID instruction neither jumps nor halts
    assign idActive  = !ifBubble && !branchTaken;
    assign jumpTaken = idActive && ctrl.isJump;
    assign halt      = fetchHalted || (idActive && ctrl.isHalt);

    assign imemAddr = pc;
    assign imemRead = !isHalted;
    assign dmemReq  = dmemReq_t'{read: memCtrl.memRead, write: memCtrl.memWrite,
                                 addr: memResult, wdata: memStoreData};

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc          <= pcReset;
            fetchHalted <= 1'b0;
            ifBubble    <= 1'b1;
            exBubble    <= 1'b1;
            exCtrl      <= ctrlNop;
            memBubble   <= 1'b1;
            memCtrl     <= ctrlNop;
            wbBubble    <= 1'b1;
            wbCtrl      <= ctrlNop;
            numInst     <= '0;
            outputPort  <= '0;
            isHalted    <= 1'b0;
        end else begin
            if (stall || halt) begin
                pc <= pc;
            end else if (branchTaken) begin
                pc <= exPc + 16'd1 + exImm;
            end else if (jumpTaken) begin
                pc <= {pc[15:12], jumpTarget(idInstr)};
            end else begin
                pc <= pc + 16'd1;
            end
            if (idActive && ctrl.isHalt) begin
                fetchHalted <= 1'b1;
            end

            // IF/ID holds on stall
            if (branchTaken || (!stall && (halt || jumpTaken))) begin
                ifBubble <= 1'b1;
            end else if (!stall) begin
                ifBubble <= 1'b0;
            end

            exBubble <= !idActive || stall;
            exCtrl   <= (idActive && !stall) ? ctrl : ctrlNop;

            memBubble <= exBubble;
            memCtrl   <= exCtrl;
            wbBubble  <= memBubble;
            wbCtrl    <= memCtrl;

            // Retire
            if (!wbBubble) begin
                numInst <= numInst + 16'd1;
                if (wbCtrl.isWwd) begin
                    outputPort <= wbResult;
                end
                if (wbCtrl.isHalt) begin
                    isHalted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin
            idInstr <= imemData;
            ifPc    <= pc;
        end
        exPc         <= ifPc;
        exRdata1     <= idRdata1;
        exRdata2     <= idRdata2;
        exImm        <= immExt(idInstr);
        exRs         <= idInstr.rs;
        exRt         <= idInstr.rt;
        exDest       <= ctrl.writeRt ? idInstr.rt : idInstr.rd;
        memResult    <= exResult;
        memStoreData <= opB;
        memDest      <= exDest;
        wbResult     <= memResult;
        wbLoad       <= dmemRdata;
        wbDest       <= memDest;
    end

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  isaPkg::regIdx_t  exRs,
    input  isaPkg::regIdx_t  exRt,
    input  isaPkg::regIdx_t  memRd,
    input  isaPkg::regIdx_t  wbRd,
    input  isaPkg::regIdx_t  idRs,
    input  isaPkg::regIdx_t  idRt,
    input  logic             memRegWrite,
    input  logic             wbRegWrite,
    input  logic             exMemRead,
    input  logic             idUseRs,
    input  logic             idUseRt,
    output pipePkg::fwdSel_t fwdA,
    output pipePkg::fwdSel_t fwdB,
    output logic             stall
);
    import isaPkg::*;
    import pipePkg::*;

    // Youngest producer wins
    function automatic fwdSel_t pickSource(regIdx_t src);
        if (memRegWrite && memRd == src) begin
            return fwdExMem;
        end else if (wbRegWrite && wbRd == src) begin
            return fwdMemWb;
        end
        return fwdNone;
    endfunction

    assign fwdA = pickSource(exRs);
    assign fwdB = pickSource(exRt);

    // A load always writes rt
    assign stall = exMemRead &&
                   ((idUseRs && idRs == exRt) || (idUseRt && idRt == exRt));

endmodule

// ==== isaPkg.sv ====
package isaPkg;

    localparam int wordW = 16;

    typedef logic [wordW-1:0] word_t;
    typedef logic [1:0] regIdx_t;

    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opAdi   = 4'd4,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opRtype = 4'd15
    } opcode_t;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } func_t;

    // Low byte is also the immediate, low 12 bits the jump target
    typedef struct packed {
        opcode_t opcode;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        func_t   func;
    } instr_t;

    function automatic word_t immExt(instr_t instr);
        logic [wordW-1:0] raw;
        raw = instr;
        return {{8{raw[7]}}, raw[7:0]};
    endfunction

    function automatic logic [11:0] jumpTarget(instr_t instr);
        logic [wordW-1:0] raw;
        raw = instr;
        return raw[11:0];
    endfunction

endpackage

// ==== pipePkg.sv ====
package pipePkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluLhi
    } aluOp_t;

    // Decoded control word, all zero acts as a no-op
    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memRead;
        logic   memWrite;
        logic   aluSrcImm;
        logic   isBranch;
        logic   branchOnEq;
        logic   isJump;
        logic   isWwd;
        logic   isHalt;
        logic   useRs;
        logic   useRt;
        logic   writeRt;
        aluOp_t aluOp;
    } ctrl_t;

    localparam ctrl_t ctrlNop = '0;

    typedef struct packed {
        logic          read;
        logic          write;
        isaPkg::word_t addr;
        isaPkg::word_t wdata;
    } dmemReq_t;

    // Source of an EX operand
    typedef enum logic [1:0] {
        fwdNone,
        fwdExMem,
        fwdMemWb
    } fwdSel_t;

endpackage

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic            Clk,
    input  logic            arstN,
    input  isaPkg::regIdx_t rs,
    input  isaPkg::regIdx_t rt,
    output isaPkg::word_t   rdata1,
    output isaPkg::word_t   rdata2,
    input  logic            we,
    input  isaPkg::regIdx_t wa,
    input  isaPkg::word_t   wd
);
    import isaPkg::*;

    word_t regs [4];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so ID sees the value retiring this cycle
    assign rdata1 = (we && wa == rs) ? wd : regs[rs];
    assign rdata2 = (we && wa == rt) ? wd : regs[rt];

endmodule

// ==== tbCpu.sv ====
`timescale 1ns/1ps

module tbCpu;
    import isaPkg::*;
    import pipePkg::*;

    logic     Clk;
    logic     arstN;
    word_t    imemAddr, imemData, dmemRdata, outputPort, numInst;
    logic     imemRead, isHalted;
    dmemReq_t dmemReq;

    word_t    imem [256];
    word_t    dmem [256];
    word_t    prog [$];
    word_t    expOut [$];
    word_t    seenOut [$];
    word_t    lastOut, lastExp;
    dmemReq_t storeSeen;
    integer   seed;

    cpu #(.pcReset(16'h0000)) dut0 (
        .Clk(Clk), .arstN(arstN),
        .imemAddr(imemAddr), .imemData(imemData), .imemRead(imemRead),
        .dmemReq(dmemReq), .dmemRdata(dmemRdata),
        .outputPort(outputPort), .numInst(numInst), .isHalted(isHalted)
    );

    // Both memories answer in the same cycle
    assign imemData  = imem[imemAddr[7:0]];
    assign dmemRdata = dmemReq.read ? dmem[dmemReq.addr[7:0]] : '0;

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    function automatic word_t immInstr(opcode_t op, regIdx_t rs, regIdx_t rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t regInstr(regIdx_t rs, regIdx_t rt, regIdx_t rd, func_t fn);
        return {opRtype, rs, rt, rd, fn};
    endfunction

    function automatic word_t jumpInstr(logic [11:0] target);
        return {opJmp, target};
    endfunction

    function automatic word_t wwdInstr(regIdx_t rs);
        return regInstr(rs, 2'd0, 2'd0, fnWwd);
    endfunction

    function automatic word_t haltInstr();
        return regInstr(2'd0, 2'd0, 2'd0, fnHlt);
    endfunction

    function automatic word_t signExt8(logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    task automatic abortRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkWord(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkReq(string name, dmemReq_t got, dmemReq_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got read=%b write=%b addr=%h wdata=%h", $time, name,
                     got.read, got.write, got.addr, got.wdata);
            $display("    expected read=%b write=%b addr=%h wdata=%h",
                     exp.read, exp.write, exp.addr, exp.wdata);
            abortRun();
        end
    endtask

    task automatic startExpect();
        expOut.delete();
        lastExp = '0;
    endtask

    // The port only shows a new value when it differs from the last one
    task automatic expectOut(word_t v);
        if (v !== lastExp) begin
            expOut.push_back(v);
            lastExp = v;
        end
    endtask

    task automatic checkOutputs();
        checkWord("outputPort count", word_t'(seenOut.size()), word_t'(expOut.size()));
        for (int i = 0; i < expOut.size(); i++) begin
            checkWord("outputPort", seenOut[i], expOut[i]);
        end
    endtask

    task automatic fillMemories();
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = haltInstr();
            dmem[i[7:0]] = {i[7:0] ^ 8'h5a, i[7:0]};
        end
        for (int i = 0; i < prog.size(); i++) begin
            imem[i[7:0]] = prog[i];
        end
    endtask

    // Samples the ports mid-cycle, commits a store just after the next edge
    task automatic stepCycle();
        dmemReq_t req;
        @(negedge Clk);
        req = dmemReq;
        if (outputPort !== lastOut) begin
            seenOut.push_back(outputPort);
            lastOut = outputPort;
        end
        @(posedge Clk);
        #1;
        if (req.write) begin
            storeSeen = req;
            dmem[req.addr[7:0]] = req.wdata;
        end
    endtask

    task automatic runProgram(int maxCycles);
        int n;
        @(posedge Clk);
        #1;
        arstN = 1'b0;
        fillMemories();
        seenOut.delete();
        lastOut   = '0;
        storeSeen = '0;
        repeat (10) @(posedge Clk);
        #1;
        arstN = 1'b1;
        n = 0;
        while (!isHalted && n < maxCycles) begin
            stepCycle();
            n++;
        end
        if (!isHalted) begin
            $display("Timeout: the core did not halt within %0d cycles", maxCycles);
            abortRun();
        end
    endtask

    task automatic arithTest();
        logic [7:0] imm1, imm2;
        word_t r1, r2, r3;
        imm1 = 8'($random(seed));
        imm2 = 8'($random(seed));
        prog = '{immInstr(opAdi, 2'd0, 2'd1, imm1), wwdInstr(2'd1),
                 immInstr(opLhi, 2'd0, 2'd2, 8'h5a), immInstr(opAdi, 2'd2, 2'd2, imm2),
                 regInstr(2'd2, 2'd1, 2'd3, fnAdd), wwdInstr(2'd3),
                 regInstr(2'd3, 2'd2, 2'd1, fnSub), wwdInstr(2'd1),
                 regInstr(2'd1, 2'd2, 2'd2, fnAnd), regInstr(2'd2, 2'd3, 2'd3, fnOrr),
                 wwdInstr(2'd3), haltInstr()};
        startExpect();
        r1 = signExt8(imm1);
        expectOut(r1);
        r2 = {8'h5a, 8'h00} + signExt8(imm2);
        r3 = r2 + r1;
        expectOut(r3);
        r1 = r3 - r2;
        expectOut(r1);
        r2 = r1 & r2;
        r3 = r2 | r3;
        expectOut(r3);
        runProgram(200);
        checkOutputs();
        checkWord("numInst", numInst, 16'd12);
    endtask

    task automatic loadStoreTest();
        dmemReq_t expReq;
        prog = '{immInstr(opAdi, 2'd0, 2'd1, 8'h21), immInstr(opAdi, 2'd0, 2'd2, 8'h3c),
                 immInstr(opSwd, 2'd2, 2'd1, 8'h05), immInstr(opLwd, 2'd2, 2'd3, 8'h05),
                 regInstr(2'd3, 2'd1, 2'd2, fnAdd), wwdInstr(2'd2), haltInstr()};
        startExpect();
        // Add uses the loaded word right after the load
        expectOut(16'h0021 + 16'h0021);
        expReq = dmemReq_t'{read: 1'b0, write: 1'b1, addr: 16'h003c + 16'h0005,
                            wdata: 16'h0021};
        runProgram(200);
        checkOutputs();
        checkReq("dmemReq", storeSeen, expReq);
        checkWord("dmem[0x41]", dmem[8'h41], 16'h0021);
        checkWord("numInst", numInst, 16'd7);
    endtask

    task automatic branchTest();
        prog = '{immInstr(opAdi, 2'd0, 2'd1, 8'h01), immInstr(opAdi, 2'd0, 2'd2, 8'h02),
                 immInstr(opBeq, 2'd1, 2'd2, 8'h01), wwdInstr(2'd1),
                 immInstr(opBne, 2'd1, 2'd2, 8'h01), wwdInstr(2'd2),
                 immInstr(opAdi, 2'd0, 2'd3, 8'h03), immInstr(opBeq, 2'd1, 2'd1, 8'h02),
                 wwdInstr(2'd2), wwdInstr(2'd2),
                 immInstr(opBne, 2'd3, 2'd3, 8'h01), wwdInstr(2'd3), haltInstr()};
        startExpect();
        expectOut(16'h0001);
        expectOut(16'h0003);
        runProgram(200);
        checkOutputs();
        checkWord("numInst", numInst, 16'd10);
    endtask

    task automatic jumpTest();
        prog = '{immInstr(opAdi, 2'd0, 2'd1, 8'h11), immInstr(opAdi, 2'd0, 2'd2, 8'h22),
                 jumpInstr(12'h005), wwdInstr(2'd2), wwdInstr(2'd2), wwdInstr(2'd1),
                 haltInstr()};
        startExpect();
        expectOut(16'h0011);
        runProgram(200);
        checkOutputs();
        checkWord("numInst", numInst, 16'd5);
    endtask

    task automatic haltResetTest();
        prog = '{immInstr(opAdi, 2'd0, 2'd1, 8'h7e), wwdInstr(2'd1), haltInstr(),
                 immInstr(opAdi, 2'd0, 2'd1, 8'h01), wwdInstr(2'd1)};
        startExpect();
        expectOut(16'h007e);
        runProgram(100);
        checkOutputs();
        checkWord("numInst", numInst, 16'd3);
        // Nothing behind HLT retires
        repeat (5) @(posedge Clk);
        #1;
        checkWord("numInst", numInst, 16'd3);
        checkWord("outputPort", outputPort, 16'h007e);
        checkWord("isHalted", word_t'(isHalted), 16'd1);
        arstN = 1'b0;
        @(negedge Clk);
        checkWord("isHalted", word_t'(isHalted), 16'd0);
        checkWord("numInst", numInst, 16'd0);
        checkWord("outputPort", outputPort, 16'd0);
    endtask

    initial begin
        arstN = 1'b0;
        seed  = 32'hbe59;
        fillMemories();
        arithTest();
        loadStoreTest();
        branchTest();
        jumpTest();
        haltResetTest();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
